// ==== flist.f ====
hw/fe2_pkg.sv
hw/fe_mul_mod.sv
hw/fe_add_sub_mod.sv
hw/fe2_mul_seq.sv
hw/fe2_mul_top.sv
testbench/tb_fe2_mul.sv

// ==== hw/fe2_mul_seq.sv ====
module fe2_mul_seq (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // fp2 operands, two beats per operation
  input  fe2_pkg::pair_stream_t i_in,
  output logic                  o_in_rdy,
  // fp multiplier
  output fe2_pkg::pair_stream_t o_mul_op,
  input  logic                  i_mul_op_rdy,
  input  fe2_pkg::fe_stream_t   i_mul_res,
  output logic                  o_mul_res_rdy,
  // subtractor for c0
  output fe2_pkg::pair_stream_t o_sub_op,
  input  logic                  i_sub_op_rdy,
  input  fe2_pkg::fe_stream_t   i_sub_res,
  output logic                  o_sub_res_rdy,
  // adder for c1
  output fe2_pkg::pair_stream_t o_add_op,
  input  logic                  i_add_op_rdy,
  input  fe2_pkg::fe_stream_t   i_add_res,
  output logic                  o_add_res_rdy,
  // fp2 result, c0 then c1
  output fe2_pkg::fe_stream_t   o_out,
  input  logic                  i_out_rdy
);
  import fe2_pkg::*;

  fe_t        a_q;          // a0
  fe_t        b_q;          // b0, then b1
  logic [1:0] issue_cnt;
  logic [1:0] collect_cnt;
  logic       out_cnt;
  logic       mul_free;
  logic       sub_free;
  logic       add_free;
  logic       out_free;
  logic       mres_xfer;

  // a register can load when empty or when its beat leaves this cycle
  always_comb begin
    mul_free  = ~o_mul_op.val | i_mul_op_rdy;
    sub_free  = ~o_sub_op.val | i_sub_op_rdy;
    add_free  = ~o_add_op.val | i_add_op_rdy;
    out_free  = ~o_out.val | i_out_rdy;
  end

  assign o_in_rdy      = ~issue_cnt[1] & mul_free;  // input only in slots 0 and 1
  assign o_mul_res_rdy = collect_cnt[1] ? add_free : sub_free;
  assign o_sub_res_rdy = ~out_cnt & out_free;
  assign o_add_res_rdy = out_cnt & out_free;
  assign mres_xfer     = i_mul_res.val & o_mul_res_rdy;

  // issue order a0b0, a1b1, a1b0, a0b1
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mul_op.val <= 1'b0;
      issue_cnt    <= 2'd0;
    end else if (mul_free) begin
      case (issue_cnt)
        2'd0: begin
          o_mul_op.val <= i_in.val;
          if (i_in.val) begin
            o_mul_op.dat <= i_in.dat;
            o_mul_op.ctl <= i_in.ctl;   // tag kept for all four products
            {b_q, a_q}   <= i_in.dat;
            issue_cnt    <= 2'd1;
          end
        end
        2'd1: begin
          o_mul_op.val <= i_in.val;
          if (i_in.val) begin
            o_mul_op.dat <= i_in.dat;   // beat 1 tag is dropped
            issue_cnt    <= 2'd2;
          end
        end
        2'd2: begin
          // lo still holds a1 from beat 1
          o_mul_op.val    <= 1'b1;
          o_mul_op.dat.hi <= b_q;
          b_q             <= o_mul_op.dat.hi;  // keep b1
          issue_cnt       <= 2'd3;
        end
        default: begin
          o_mul_op.val    <= 1'b1;
          o_mul_op.dat.hi <= a_q;
          o_mul_op.dat.lo <= b_q;
          issue_cnt       <= 2'd0;
        end
      endcase
    end
  end

  // products come back in issue order
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_sub_op.val <= 1'b0;
      o_add_op.val <= 1'b0;
      collect_cnt  <= 2'd0;
    end else begin
      if (o_sub_op.val && i_sub_op_rdy) begin
        o_sub_op.val <= 1'b0;
      end
      if (o_add_op.val && i_add_op_rdy) begin
        o_add_op.val <= 1'b0;
      end
      if (mres_xfer) begin
        collect_cnt <= collect_cnt + 2'd1;
        case (collect_cnt)
          2'd0: o_sub_op.dat.lo <= i_mul_res.dat;  // a0b0
          2'd1: begin
            o_sub_op.dat.hi <= i_mul_res.dat;      // a1b1
            o_sub_op.ctl    <= i_mul_res.ctl;
            o_sub_op.val    <= 1'b1;
          end
          2'd2: o_add_op.dat.lo <= i_mul_res.dat;  // a1b0
          default: begin
            o_add_op.dat.hi <= i_mul_res.dat;      // a0b1
            o_add_op.ctl    <= i_mul_res.ctl;
            o_add_op.val    <= 1'b1;
          end
        endcase
      end
    end
  end

  // c0 from the subtractor is the sop beat, c1 from the adder the eop beat
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_out.val <= 1'b0;
      out_cnt   <= 1'b0;
    end else if (out_free) begin
      if (!out_cnt) begin
        o_out.val <= i_sub_res.val;
        if (i_sub_res.val) begin
          o_out.dat <= i_sub_res.dat;
          o_out.ctl <= i_sub_res.ctl;
          o_out.sop <= 1'b1;
          o_out.eop <= 1'b0;
          out_cnt   <= 1'b1;
        end
      end else begin
        o_out.val <= i_add_res.val;
        if (i_add_res.val) begin
          o_out.dat <= i_add_res.dat;
          o_out.ctl <= i_add_res.ctl;
          o_out.sop <= 1'b0;
          o_out.eop <= 1'b1;
          out_cnt   <= 1'b0;
        end
      end
    end
  end

  a_sop_eop_excl: assert property (@(posedge i_clk) disable iff (i_rst)
    o_out.val |-> !(o_out.sop && o_out.eop));

endmodule

// ==== hw/fe2_mul_top.sv ====
module fe2_mul_top (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  fe2_pkg::pair_stream_t i_in,
  output logic                  o_in_rdy,
  output fe2_pkg::fe_stream_t   o_out,
  input  logic                  i_out_rdy
);
  import fe2_pkg::*;

  pair_stream_t mul_op;
  logic         mul_op_rdy;
  fe_stream_t   mul_res;
  logic         mul_res_rdy;

  pair_stream_t sub_op;
  logic         sub_op_rdy;
  fe_stream_t   sub_res;
  logic         sub_res_rdy;

  pair_stream_t add_op;
  logic         add_op_rdy;
  fe_stream_t   add_res;
  logic         add_res_rdy;

  fe2_mul_seq fe2_mul_seq_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_in          (i_in),
    .o_in_rdy      (o_in_rdy),
    .o_mul_op      (mul_op),
    .i_mul_op_rdy  (mul_op_rdy),
    .i_mul_res     (mul_res),
    .o_mul_res_rdy (mul_res_rdy),
    .o_sub_op      (sub_op),
    .i_sub_op_rdy  (sub_op_rdy),
    .i_sub_res     (sub_res),
    .o_sub_res_rdy (sub_res_rdy),
    .o_add_op      (add_op),
    .i_add_op_rdy  (add_op_rdy),
    .i_add_res     (add_res),
    .o_add_res_rdy (add_res_rdy),
    .o_out         (o_out),
    .i_out_rdy     (i_out_rdy)
  );

  fe_mul_mod fe_mul_mod_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_op      (mul_op),
    .o_op_rdy  (mul_op_rdy),
    .o_res     (mul_res),
    .i_res_rdy (mul_res_rdy)
  );

  // c0 = a0b0 - a1b1
  fe_add_sub_mod #(.SUBTRACT(1'b1)) fe_sub_mod_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_op      (sub_op),
    .o_op_rdy  (sub_op_rdy),
    .o_res     (sub_res),
    .i_res_rdy (sub_res_rdy)
  );

  // c1 = a1b0 + a0b1
  fe_add_sub_mod #(.SUBTRACT(1'b0)) fe_add_mod_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_op      (add_op),
    .o_op_rdy  (add_op_rdy),
    .o_res     (add_res),
    .i_res_rdy (add_res_rdy)
  );

endmodule

// ==== hw/fe2_pkg.sv ====
package fe2_pkg;

  // base field is the mersenne prime 2^31 - 1
  localparam int FE_BITS  = 31;
  localparam logic [FE_BITS-1:0] FE_P = 31'h7fff_ffff;

  localparam int CTL_BITS = 8;  // user tag carried with every operation
  localparam int MUL_LAT  = 3;  // stages in fe_mul_mod

  typedef logic [FE_BITS-1:0] fe_t;

  // operand pair, {b, a} into the multiplier or {hi, lo} into add/sub
  typedef struct packed {
    fe_t hi;
    fe_t lo;
  } fe_pair_t;

  // forward half of an operand stream
  typedef struct packed {
    fe_pair_t            dat;
    logic [CTL_BITS-1:0] ctl;
    logic                val;
  } pair_stream_t;

  // forward half of a result stream
  // sop/eop only mean something on the fp2 output
  typedef struct packed {
    fe_t                 dat;
    logic [CTL_BITS-1:0] ctl;
    logic                sop;
    logic                eop;
    logic                val;
  } fe_stream_t;

endpackage

// ==== hw/fe_add_sub_mod.sv ====
module fe_add_sub_mod #(
  parameter bit SUBTRACT = 1'b0
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  fe2_pkg::pair_stream_t i_op,
  output logic                  o_op_rdy,
  output fe2_pkg::fe_stream_t   o_res,
  input  logic                  i_res_rdy
);
  import fe2_pkg::*;

  logic                take;
  logic [FE_BITS:0]    raw;   // carry or borrow in the top bit
  logic [FE_BITS:0]    adj;
  fe_t                 res;
  logic                val_q;
  fe_t                 dat_q;
  logic [CTL_BITS-1:0] ctl_q;

  assign o_op_rdy = ~val_q | i_res_rdy;
  assign take     = i_op.val & o_op_rdy;

  always_comb begin
    if (SUBTRACT) begin
      raw = {1'b0, i_op.dat.lo} - {1'b0, i_op.dat.hi};
      adj = raw + {1'b0, FE_P};
      res = raw[FE_BITS] ? adj[FE_BITS-1:0] : raw[FE_BITS-1:0];  // borrow wraps by p
    end else begin
      raw = {1'b0, i_op.dat.lo} + {1'b0, i_op.dat.hi};
      adj = raw - {1'b0, FE_P};
      res = (raw >= {1'b0, FE_P}) ? adj[FE_BITS-1:0] : raw[FE_BITS-1:0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q <= 1'b0;
    end else if (o_op_rdy) begin
      val_q <= i_op.val;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      dat_q <= res;
      ctl_q <= i_op.ctl;
    end
  end

  always_comb begin
    o_res.dat = dat_q;
    o_res.ctl = ctl_q;
    o_res.sop = 1'b0;
    o_res.eop = 1'b0;
    o_res.val = val_q;
  end

  a_hold_on_stall: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_res.val && !i_res_rdy) |=> $stable(o_res));

endmodule

// ==== hw/fe_mul_mod.sv ====
module fe_mul_mod (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  fe2_pkg::pair_stream_t i_op,
  output logic                  o_op_rdy,
  output fe2_pkg::fe_stream_t   o_res,
  input  logic                  i_res_rdy
);
  import fe2_pkg::*;

  logic                 en;
  logic [MUL_LAT-1:0]   vld_q;              // one valid bit per stage
  logic [CTL_BITS-1:0]  ctl_q [MUL_LAT];
  logic [2*FE_BITS-1:0] prod_q;             // stage 1, full product
  logic [FE_BITS:0]     fold1;
  logic [FE_BITS:0]     fold2;
  logic [FE_BITS:0]     fold_q;             // stage 2, at most 2^31
  logic [FE_BITS:0]     fold_sub;
  fe_t                  res_q;              // stage 3

  // whole pipe freezes while the output beat is held
  assign en       = ~vld_q[MUL_LAT-1] | i_res_rdy;
  assign o_op_rdy = en;

  // 2^31 == 1 mod p, so high half folds straight onto low half
  always_comb begin
    fold1    = {1'b0, prod_q[2*FE_BITS-1:FE_BITS]} + {1'b0, prod_q[FE_BITS-1:0]};
    fold2    = {1'b0, fold1[FE_BITS-1:0]} + {{FE_BITS{1'b0}}, fold1[FE_BITS]};
    fold_sub = fold_q - {1'b0, FE_P};
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      vld_q <= '0;
    end else if (en) begin
      vld_q <= {vld_q[MUL_LAT-2:0], i_op.val};
    end
  end

  always_ff @(posedge i_clk) begin
    if (en) begin
      prod_q <= (2*FE_BITS)'(i_op.dat.hi) * (2*FE_BITS)'(i_op.dat.lo);
      fold_q <= fold2;
      // one conditional subtract is enough after the second fold
      if (fold_q >= {1'b0, FE_P}) begin
        res_q <= fold_sub[FE_BITS-1:0];
      end else begin
        res_q <= fold_q[FE_BITS-1:0];
      end
      ctl_q[0] <= i_op.ctl;
      for (int i = 1; i < MUL_LAT; i++) begin
        ctl_q[i] <= ctl_q[i-1];  // tag rides with the data
      end
    end
  end

  always_comb begin
    o_res.dat = res_q;
    o_res.ctl = ctl_q[MUL_LAT-1];
    o_res.sop = 1'b0;
    o_res.eop = 1'b0;
    o_res.val = vld_q[MUL_LAT-1];
  end

  // reduction must land fully inside the field
  a_res_in_range: assert property (@(posedge i_clk) disable iff (i_rst)
    o_res.val |-> (o_res.dat < FE_P));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the Fp2 multiplier testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fe2_mul -f flist.f -o tb_fe2_mul > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/tb_fe2_mul > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Some tests failed" "$SIM_LOG"; then
  echo "FAIL"
  exit 1
fi
if ! grep -q "All tests passed" "$SIM_LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
echo "PASS"
exit 0

// ==== testbench/tb_fe2_mul.sv ====
module tb_fe2_mul;
  import fe2_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int WAIT_LIMIT   = 2000;  // cycles before any wait gives up

  logic         i_clk;
  logic         i_rst;
  pair_stream_t i_in;
  logic         o_in_rdy;
  fe_stream_t   o_out;
  logic         i_out_rdy;

  fe_stream_t          exp_q [$];   // expected output beats, in order
  string               name_q [$];
  logic [31:0]         stim_state;
  logic [31:0]         bp_state;
  logic                bp_en = 1'b0;
  int                  mismatch_cnt = 0;
  int                  other_cnt = 0;
  int                  ops_sent = 0;
  int                  frames = 0;
  logic                sop_open = 1'b0;
  logic [CTL_BITS-1:0] sop_tag;

  fe2_mul_top fe2_mul_top_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_in      (i_in),
    .o_in_rdy  (o_in_rdy),
    .o_out     (o_out),
    .i_out_rdy (i_out_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic fe_t rand_fe();
    stim_state = xorshift(stim_state);
    return fe_t'(stim_state % 32'(FE_P));  // canonical element
  endfunction

  function automatic fe_t mod_mul(input fe_t x, input fe_t y);
    logic [63:0] p;
    p = 64'(x) * 64'(y);
    return fe_t'(p % 64'(FE_P));
  endfunction

  // (a0 + a1 u)(b0 + b1 u) with u^2 = -1
  task automatic fp2_model(input fe_t a0, input fe_t a1, input fe_t b0, input fe_t b1,
                           output fe_t c0, output fe_t c1);
    c0 = fe_t'((64'(mod_mul(a0, b0)) + 64'(FE_P) - 64'(mod_mul(a1, b1))) % 64'(FE_P));
    c1 = fe_t'((64'(mod_mul(a1, b0)) + 64'(mod_mul(a0, b1))) % 64'(FE_P));
  endtask

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected %0h, actual %0h", name, exp_v, act_v);
    end
  endtask

  task automatic report_failure(input string what);
    other_cnt++;
    $display("%s", what);
  endtask

  task automatic abort_run(input string what);
    report_failure(what);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    $display("Some tests failed");
    $finish;
  endtask

  // called 1 unit after a rising edge, returns 1 unit after the accepting edge
  task automatic send_beat(input fe_pair_t dat, input logic [CTL_BITS-1:0] ctl);
    int waited;
    waited = 0;
    i_in.dat = dat;
    i_in.ctl = ctl;
    i_in.val = 1'b1;
    @(negedge i_clk);
    while (!o_in_rdy) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout: input beat was never accepted");
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #1;
    i_in.val = 1'b0;
  endtask

  task automatic run_op(input fe_t a0, input fe_t a1, input fe_t b0, input fe_t b1,
                        input logic [CTL_BITS-1:0] ctl, input string name);
    fe_t        c0;
    fe_t        c1;
    fe_stream_t beat;
    fp2_model(a0, a1, b0, b1, c0, c1);
    send_beat({b0, a0}, ctl);
    beat = '{dat: c0, ctl: ctl, sop: 1'b1, eop: 1'b0, val: 1'b1};
    exp_q.push_back(beat);
    name_q.push_back({name, " c0"});
    send_beat({b1, a1}, ~ctl);  // second tag must be ignored
    beat = '{dat: c1, ctl: ctl, sop: 1'b0, eop: 1'b1, val: 1'b1};
    exp_q.push_back(beat);
    name_q.push_back({name, " c1"});
    ops_sent++;
  endtask

  // output rdy, about 30 percent low when enabled
  initial begin
    bp_state  = 32'd70794 ^ 32'h9e37_79b9;
    i_out_rdy = 1'b1;
    forever begin
      @(posedge i_clk);
      #1;
      if (bp_en) begin
        bp_state  = xorshift(bp_state);
        i_out_rdy = (bp_state % 32'd10) >= 32'd3;
      end else begin
        i_out_rdy = 1'b1;
      end
    end
  end

  // inputs settle 1 unit after the edge, so negedge sees the next transfer
  always @(negedge i_clk) begin
    fe_stream_t e;
    string      nm;
    if (!i_rst && o_out.val && i_out_rdy) begin
      if (o_out.sop && o_out.eop) report_failure("output beat has sop and eop both high");
      if (exp_q.size() == 0) begin
        report_failure("output beat arrived with no result outstanding");
      end else begin
        e  = exp_q.pop_front();
        nm = name_q.pop_front();
        check_value({nm, " dat"}, 64'(e.dat), 64'(o_out.dat));
        check_value({nm, " ctl"}, 64'(e.ctl), 64'(o_out.ctl));
        check_value({nm, " sop"}, 64'(e.sop), 64'(o_out.sop));
        check_value({nm, " eop"}, 64'(e.eop), 64'(o_out.eop));
      end
      if (o_out.sop) begin
        if (sop_open) report_failure("sop beat arrived before the previous frame ended");
        sop_open = 1'b1;
        sop_tag  = o_out.ctl;
      end else if (o_out.eop) begin
        if (!sop_open) report_failure("eop beat arrived without a preceding sop beat");
        else check_value("eop tag", 64'(sop_tag), 64'(o_out.ctl));
        sop_open = 1'b0;
        frames++;
      end else begin
        report_failure("output beat has neither sop nor eop");
      end
    end
  end

  initial begin
    int  waited;
    fe_t a0;
    fe_t a1;
    fe_t b0;
    fe_t b1;
    fe_t c0;
    fe_t c1;
    fe_t edge_v [3];
    stim_state = 32'd70794;
    edge_v[0]  = '0;
    edge_v[1]  = fe_t'(1);
    edge_v[2]  = FE_P - fe_t'(1);
    i_rst      = 1'b1;
    i_in       = '0;
    repeat (RESET_CYCLES) begin
      @(posedge i_clk);
      #1;
      check_value("reset o_out.val", 64'd0, 64'(o_out.val));
    end
    i_rst = 1'b0;
    waited = 0;
    @(negedge i_clk);
    while (!o_in_rdy) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout: o_in_rdy never rose after reset");
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #1;
    check_value("post reset o_out.val", 64'd0, 64'(o_out.val));

    for (int i = 0; i < 200; i++) begin
      a0 = rand_fe();
      a1 = rand_fe();
      b0 = rand_fe();
      b1 = rand_fe();
      run_op(a0, a1, b0, b1, CTL_BITS'(i), "random");
      if (stim_state[1:0] == 2'd0) begin
        @(posedge i_clk);  // idle gap between operations
        #1;
      end
    end

    // model against u*u = -1
    fp2_model('0, fe_t'(1), '0, fe_t'(1), c0, c1);
    check_value("model u*u c0", 64'(FE_P - fe_t'(1)), 64'(c0));
    check_value("model u*u c1", 64'd0, 64'(c1));

    // every mix of 0, 1, p-1 over the four coefficients
    for (int idx = 0; idx < 81; idx++) begin
      run_op(edge_v[idx % 3], edge_v[(idx / 3) % 3], edge_v[(idx / 9) % 3],
             edge_v[(idx / 27) % 3], CTL_BITS'(idx + 200), "edge");
    end

    bp_en = 1'b1;
    for (int i = 0; i < 150; i++) begin
      a0 = rand_fe();
      a1 = rand_fe();
      b0 = rand_fe();
      b1 = rand_fe();
      run_op(a0, a1, b0, b1, CTL_BITS'(i + 37), "backpressure");
    end
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout: results still outstanding at end of run");
    end
    bp_en = 1'b0;

    check_value("frame count", 64'(ops_sent), 64'(frames));
    if (sop_open) report_failure("last output frame never got its eop beat");
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
